// File: rtl/tlul_pkg.sv
`default_nettype none

package tlul_pkg;

  // Bus widths
  localparam int unsigned AddrW   = 32;
  localparam int unsigned DataW   = 32;
  localparam int unsigned MaskW   = DataW / 8;
  localparam int unsigned SourceW = 4;

  typedef logic [AddrW-1:0]   tl_addr_t;
  typedef logic [DataW-1:0]   tl_data_t;
  typedef logic [MaskW-1:0]   tl_mask_t;
  typedef logic [SourceW-1:0] tl_source_t;

  // A channel opcodes, reduced set
  typedef enum logic [2:0] {
    PutFullData = 3'h0,
    Get         = 3'h4
  } tl_a_op_e;

  // D channel opcodes
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  // Request beat
  typedef struct packed {
    tl_a_op_e   opcode;
    tl_addr_t   address;
    tl_mask_t   mask;
    tl_data_t   data;
    tl_source_t source;
  } tl_a_t;

  // Response beat
  typedef struct packed {
    tl_d_op_e   opcode;
    tl_data_t   data;
    tl_source_t source;
    logic       error;
  } tl_d_t;

endpackage

`default_nettype wire

// File: rtl/tlul_link_if.sv
`default_nettype none

interface tlul_link_if import tlul_pkg::*; ();

  // Request channel
  logic  a_valid;
  logic  a_ready;
  tl_a_t a;

  // Response channel
  logic  d_valid;
  logic  d_ready;
  tl_d_t d;

  // Requesting side
  modport host (
    output a_valid, a, d_ready,
    input  a_ready, d_valid, d
  );

  // Responding side
  modport device (
    input  a_valid, a, d_ready,
    output a_ready, d_valid, d
  );

endinterface

`default_nettype wire

// File: rtl/tlul_fifo.sv
`default_nettype none

module tlul_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned Depth     = 2,
  parameter bit          Pass      = 1'b1
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  // Depth 0 keeps one dummy slot and relies on pass-through
  localparam int unsigned Slots = (Depth > 0) ? Depth : 1;
  localparam int unsigned PtrW  = (Slots > 1) ? $clog2(Slots) : 1;
  localparam int unsigned CntW  = $clog2(Slots + 1);

  payload_t        mem_q [Slots];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;

  logic empty;
  logic pass_now;
  logic push;
  logic pop;

  assign empty    = (count_q == '0);
  // Bypass the buffer only while nothing is queued
  assign pass_now = Pass && empty;

  assign valid_o = pass_now ? valid_i : !empty;
  assign data_o  = pass_now ? data_i : mem_q[rd_ptr_q];

  // Room left, or the beat goes straight out
  assign ready_o = (count_q < Depth) || (pass_now && ready_i);

  // Store only what the output did not take
  assign push = valid_i && ready_o && !(pass_now && ready_i);
  assign pop  = !empty && ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        // Wrap at the last slot
        wr_ptr_q <= (wr_ptr_q == PtrW'(Slots - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Slots - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/tlul_fifo_pair.sv
`default_nettype none

module tlul_fifo_pair import tlul_pkg::*; #(
  parameter int unsigned Depth = 2,
  parameter bit          Pass  = 1'b1
) (
  input  logic        clk_i,
  input  logic        reset_i,
  tlul_link_if.device up,
  tlul_link_if.host   dn
);

  // Requests flow from up to dn
  tlul_fifo #(
    .payload_t (tl_a_t),
    .Depth     (Depth),
    .Pass      (Pass)
  ) u_req_fifo (
    .clk_i,
    .reset_i,
    .valid_i (up.a_valid),
    .ready_o (up.a_ready),
    .data_i  (up.a),
    .valid_o (dn.a_valid),
    .ready_i (dn.a_ready),
    .data_o  (dn.a)
  );

  // Responses flow back from dn to up
  tlul_fifo #(
    .payload_t (tl_d_t),
    .Depth     (Depth),
    .Pass      (Pass)
  ) u_rsp_fifo (
    .clk_i,
    .reset_i,
    .valid_i (dn.d_valid),
    .ready_o (dn.d_ready),
    .data_i  (dn.d),
    .valid_o (up.d_valid),
    .ready_i (up.d_ready),
    .data_o  (up.d)
  );

endmodule

`default_nettype wire

// File: rtl/tlul_rr_arbiter.sv
`default_nettype none

module tlul_rr_arbiter import tlul_pkg::*; #(
  parameter int unsigned M = 2
) (
  input  logic         clk_i,
  input  logic         reset_i,
  input  logic [M-1:0] req_i,
  input  tl_a_t        data_i [M],
  output logic [M-1:0] gnt_o,
  output logic         valid_o,
  output tl_a_t        data_o,
  input  logic         ready_i
);

  localparam int unsigned IdxW = (M > 1) ? $clog2(M) : 1;

  // Search start point
  logic [IdxW-1:0] ptr_q;
  // Winner locked while the output stalls
  logic            hold_q;
  logic [IdxW-1:0] hold_idx_q;

  logic            found;
  logic [IdxW-1:0] pick_idx;
  logic [IdxW-1:0] win_idx;
  logic            xfer;

  // First requester at or after the pointer
  always_comb begin
    int unsigned cand;
    found    = 1'b0;
    pick_idx = '0;
    for (int unsigned k = 0; k < M; k++) begin
      cand = (ptr_q + k) % M;
      if (!found && req_i[cand]) begin
        found    = 1'b1;
        pick_idx = IdxW'(cand);
      end
    end
  end

  assign win_idx = hold_q ? hold_idx_q : pick_idx;
  assign valid_o = hold_q ? req_i[hold_idx_q] : found;
  assign data_o  = data_i[win_idx];
  assign xfer    = valid_o && ready_i;

  // Grant doubles as the winner's ready
  always_comb begin
    gnt_o = '0;
    if (xfer) begin
      gnt_o[win_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q      <= '0;
      hold_q     <= 1'b0;
      hold_idx_q <= '0;
    end else if (xfer) begin
      hold_q <= 1'b0;
      // Step past the winner for fairness
      ptr_q  <= (win_idx == IdxW'(M - 1)) ? '0 : win_idx + 1'b1;
    end else if (valid_o) begin
      hold_q     <= 1'b1;
      hold_idx_q <= win_idx;
    end
  end

endmodule

`default_nettype wire

// File: rtl/tlul_socket_m1.sv
`default_nettype none

module tlul_socket_m1 import tlul_pkg::*; #(
  parameter int unsigned M         = 2,
  parameter int unsigned HostDepth = 2,
  parameter bit          HostPass  = 1'b1,
  parameter int unsigned DevDepth  = 2,
  parameter bit          DevPass   = 1'b1
) (
  input  logic        clk_i,
  input  logic        reset_i,
  tlul_link_if.device host [M],
  tlul_link_if.host   dev
);

  // Low source bits that name the host
  localparam int unsigned IdW = $clog2(M);

  // Host side, before and after the host FIFOs
  tlul_link_if host_in [M] ();
  tlul_link_if host_out [M] ();
  // Arbiter output into the device FIFO
  tlul_link_if arb_link ();

  logic  [M-1:0] arb_req;
  logic  [M-1:0] arb_gnt;
  tl_a_t         arb_data [M];
  logic  [M-1:0] rsp_take;
  tl_d_t         rsp_restored;

  // Shift the host index back out, top bits come back as zero
  always_comb begin
    rsp_restored        = arb_link.d;
    rsp_restored.source = {{IdW{1'b0}}, arb_link.d.source[SourceW-1:IdW]};
  end

  for (genvar i = 0; i < M; i++) begin : gen_host
    tl_a_t req_shifted;
    tl_d_t rsp_out;
    logic  rsp_hit;

    // Host index replaces the low source bits
    always_comb begin
      req_shifted        = host[i].a;
      req_shifted.source = {host[i].a.source[SourceW-1:IdW], IdW'(i)};
    end

    // Error flag only rides on a valid beat
    always_comb begin
      rsp_out       = host_in[i].d;
      rsp_out.error = host_in[i].d.error & host_in[i].d_valid;
    end

    assign host_in[i].a_valid = host[i].a_valid;
    assign host_in[i].a       = req_shifted;
    assign host_in[i].d_ready = host[i].d_ready;
    assign host[i].a_ready    = host_in[i].a_ready;
    assign host[i].d_valid    = host_in[i].d_valid;
    assign host[i].d          = rsp_out;

    tlul_fifo_pair #(
      .Depth (HostDepth),
      .Pass  (HostPass)
    ) u_host_fifo (
      .clk_i,
      .reset_i,
      .up (host_in[i]),
      .dn (host_out[i])
    );

    // Arbiter request side
    assign arb_req[i]          = host_out[i].a_valid;
    assign arb_data[i]         = host_out[i].a;
    assign host_out[i].a_ready = arb_gnt[i];

    // Steer the response by its low source bits
    assign rsp_hit             = (arb_link.d.source[IdW-1:0] == IdW'(i));
    assign host_out[i].d_valid = arb_link.d_valid & rsp_hit;
    assign host_out[i].d       = rsp_restored;
    assign rsp_take[i]         = host_out[i].d_ready & rsp_hit;
  end

  tlul_rr_arbiter #(
    .M (M)
  ) u_arb (
    .clk_i,
    .reset_i,
    .req_i   (arb_req),
    .data_i  (arb_data),
    .gnt_o   (arb_gnt),
    .valid_o (arb_link.a_valid),
    .data_o  (arb_link.a),
    .ready_i (arb_link.a_ready)
  );

  // Only the addressed host can pop the response
  assign arb_link.d_ready = |rsp_take;

  tlul_fifo_pair #(
    .Depth (DevDepth),
    .Pass  (DevPass)
  ) u_dev_fifo (
    .clk_i,
    .reset_i,
    .up (arb_link),
    .dn (dev)
  );

endmodule

`default_nettype wire

// File: rtl/tlul_sram_dev.sv
`default_nettype none

module tlul_sram_dev import tlul_pkg::*; #(
  parameter int unsigned MemWords = 16
) (
  input  logic        clk_i,
  input  logic        reset_i,
  tlul_link_if.device tl
);

  localparam int unsigned IdxW = (MemWords > 1) ? $clog2(MemWords) : 1;

  tl_data_t        mem_q [MemWords];
  logic            rsp_valid_q;
  tl_d_t           rsp_q;
  logic            accept;
  logic            in_range;
  logic            is_get;
  logic [IdxW-1:0] word_idx;
  tl_data_t        wr_word;

  // Word addressing, byte offset ignored
  assign word_idx = tl.a.address[IdxW+1:2];
  assign in_range = (tl.a.address < tl_addr_t'(MemWords * 4));
  assign is_get   = (tl.a.opcode == Get);

  // Stall new requests while a response sits unread
  assign tl.a_ready = !rsp_valid_q || tl.d_ready;
  assign accept     = tl.a_valid && tl.a_ready;
  assign tl.d_valid = rsp_valid_q;
  assign tl.d       = rsp_q;

  // Merge enabled bytes into the stored word
  always_comb begin
    wr_word = mem_q[word_idx];
    for (int b = 0; b < MaskW; b++) begin
      if (tl.a.mask[b]) begin
        wr_word[8*b +: 8] = tl.a.data[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int w = 0; w < MemWords; w++) begin
        mem_q[w] <= '0;
      end
    end else if (accept && in_range && !is_get) begin
      mem_q[word_idx] <= wr_word;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (tl.d_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Response beat, source echoed back
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_q.opcode <= is_get ? AccessAckData : AccessAck;
      rsp_q.data   <= (is_get && in_range) ? mem_q[word_idx] : '0;
      rsp_q.source <= tl.a.source;
      rsp_q.error  <= !in_range;
    end
  end

endmodule

`default_nettype wire

// File: rtl/tlul_xbar_top.sv
`default_nettype none

module tlul_xbar_top import tlul_pkg::*; #(
  parameter int unsigned M         = 2,
  parameter int unsigned HostDepth = 2,
  parameter int unsigned DevDepth  = 2,
  parameter bit          HostPass  = 1'b1,
  parameter bit          DevPass   = 1'b1,
  parameter int unsigned MemWords  = 16
) (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       host_a_valid_i   [M],
  input  tl_a_op_e   host_a_opcode_i  [M],
  input  tl_addr_t   host_a_address_i [M],
  input  tl_mask_t   host_a_mask_i    [M],
  input  tl_data_t   host_a_data_i    [M],
  input  tl_source_t host_a_source_i  [M],
  input  logic       host_d_ready_i   [M],
  output logic       host_a_ready_o   [M],
  output logic       host_d_valid_o   [M],
  output tl_d_op_e   host_d_opcode_o  [M],
  output tl_data_t   host_d_data_o    [M],
  output tl_source_t host_d_source_o  [M],
  output logic       host_d_error_o   [M]
);

  tlul_link_if host_link [M] ();
  tlul_link_if dev_link ();

  // Pack and unpack the flat host ports
  for (genvar i = 0; i < M; i++) begin : gen_host_port
    assign host_link[i].a_valid = host_a_valid_i[i];
    assign host_link[i].a = '{
      opcode:  host_a_opcode_i[i],
      address: host_a_address_i[i],
      mask:    host_a_mask_i[i],
      data:    host_a_data_i[i],
      source:  host_a_source_i[i]
    };
    assign host_link[i].d_ready = host_d_ready_i[i];

    assign host_a_ready_o[i]  = host_link[i].a_ready;
    assign host_d_valid_o[i]  = host_link[i].d_valid;
    assign host_d_opcode_o[i] = host_link[i].d.opcode;
    assign host_d_data_o[i]   = host_link[i].d.data;
    assign host_d_source_o[i] = host_link[i].d.source;
    assign host_d_error_o[i]  = host_link[i].d.error;
  end

  tlul_socket_m1 #(
    .M         (M),
    .HostDepth (HostDepth),
    .HostPass  (HostPass),
    .DevDepth  (DevDepth),
    .DevPass   (DevPass)
  ) u_socket (
    .clk_i,
    .reset_i,
    .host (host_link),
    .dev  (dev_link)
  );

  tlul_sram_dev #(
    .MemWords (MemWords)
  ) u_sram (
    .clk_i,
    .reset_i,
    .tl (dev_link)
  );

endmodule

`default_nettype wire

// File: verification/tlul_xbar_assertions.sv
`default_nettype none

module tlul_xbar_assertions import tlul_pkg::*; #(
  parameter int unsigned M = 2
) (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       host_a_valid_i   [M],
  input  logic       host_a_ready_o   [M],
  input  tl_a_op_e   host_a_opcode_i  [M],
  input  tl_addr_t   host_a_address_i [M],
  input  tl_mask_t   host_a_mask_i    [M],
  input  tl_data_t   host_a_data_i    [M],
  input  tl_source_t host_a_source_i  [M],
  input  logic       host_d_ready_i   [M],
  input  logic       host_d_valid_o   [M],
  input  tl_d_op_e   host_d_opcode_o  [M],
  input  tl_data_t   host_d_data_o    [M],
  input  tl_source_t host_d_source_o  [M],
  input  logic       host_d_error_o   [M]
);

  for (genvar i = 0; i < M; i++) begin : gen_host
    // Stalled request beat stays put
    a_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      host_a_valid_i[i] && !host_a_ready_o[i] |=> host_a_valid_i[i] &&
      $stable(host_a_opcode_i[i]) && $stable(host_a_address_i[i]) &&
      $stable(host_a_mask_i[i]) && $stable(host_a_data_i[i]) && $stable(host_a_source_i[i]))
      else $error("host %0d A channel changed before ready", i);

    // Nothing comes back right out of reset
    d_idle: assert property (@(posedge clk_i) reset_i |=> !host_d_valid_o[i])
      else $error("host %0d D valid high after reset", i);

    // Error flag never shows without a response beat
    d_err_valid: assert property (@(posedge clk_i) disable iff (reset_i)
      host_d_error_o[i] |-> host_d_valid_o[i])
      else $error("host %0d D error high without valid", i);

    // Stalled response beat stays put too
    d_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      host_d_valid_o[i] && !host_d_ready_i[i] |=> host_d_valid_o[i] &&
      $stable(host_d_opcode_o[i]) && $stable(host_d_data_o[i]) &&
      $stable(host_d_source_o[i]) && $stable(host_d_error_o[i]))
      else $error("host %0d D channel changed before ready", i);
  end

endmodule

`default_nettype wire

// File: verification/tlul_xbar_tb.sv
`default_nettype none

module tlul_xbar_tb import tlul_pkg::*; ();

  localparam int unsigned M        = 2;
  localparam int unsigned MemWords = 16;
  localparam int unsigned MemBytes = MemWords * 4;

  // One stimulus row and its expected response
  typedef struct {
    int         host;
    bit         both;
    bit         stall;
    tl_a_op_e   op;
    tl_addr_t   addr;
    tl_mask_t   mask;
    tl_data_t   data;
    tl_source_t src;
    tl_d_op_e   exp_op;
    tl_data_t   exp_data;
    logic       exp_err;
  } row_t;

  typedef struct {
    tl_d_op_e   op;
    tl_data_t   data;
    tl_source_t src;
    logic       err;
  } rsp_t;

  logic       clk_i = 1'b0;
  logic       reset_i;
  logic       a_valid [M];
  tl_a_op_e   a_opcode [M];
  tl_addr_t   a_address [M];
  tl_mask_t   a_mask [M];
  tl_data_t   a_data [M];
  tl_source_t a_source [M];
  logic       d_ready [M];
  logic       a_ready [M];
  logic       d_valid [M];
  tl_d_op_e   d_opcode [M];
  tl_data_t   d_data [M];
  tl_source_t d_source [M];
  logic       d_error [M];

  row_t     rows [$];
  tl_data_t ref_mem [MemWords];
  rsp_t     got_q0 [$];
  rsp_t     got_q1 [$];
  bit       stall_on = 1'b0;

  tlul_xbar_top #(
    .M (M), .HostDepth (2), .DevDepth (2),
    .HostPass (1'b0), .DevPass (1'b1), .MemWords (MemWords)
  ) uut (
    .clk_i, .reset_i,
    .host_a_valid_i (a_valid), .host_a_opcode_i (a_opcode),
    .host_a_address_i (a_address), .host_a_mask_i (a_mask),
    .host_a_data_i (a_data), .host_a_source_i (a_source),
    .host_d_ready_i (d_ready), .host_a_ready_o (a_ready),
    .host_d_valid_o (d_valid), .host_d_opcode_o (d_opcode),
    .host_d_data_o (d_data), .host_d_source_o (d_source),
    .host_d_error_o (d_error)
  );

  bind tlul_xbar_top tlul_xbar_assertions #(.M (M)) u_assertions (
    .clk_i, .reset_i, .host_a_valid_i, .host_a_ready_o, .host_a_opcode_i,
    .host_a_address_i, .host_a_mask_i, .host_a_data_i, .host_a_source_i,
    .host_d_ready_i, .host_d_valid_o, .host_d_opcode_o, .host_d_data_o,
    .host_d_source_o, .host_d_error_o
  );

  always #10 clk_i = ~clk_i;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_data(input tl_data_t got, input tl_data_t exp, input int r);
    if (got !== exp) begin
      stop_on_error($sformatf("FAIL %0t: row %0d data %h, expected %h", $time, r, got, exp));
    end
  endtask

  task automatic check_source(input tl_source_t got, input tl_source_t exp, input int r);
    if (got !== exp) begin
      stop_on_error($sformatf("FAIL %0t: row %0d source %h, expected %h", $time, r, got, exp));
    end
  endtask

  task automatic check_opcode(input tl_d_op_e got, input tl_d_op_e exp, input int r);
    if (got !== exp) begin
      stop_on_error($sformatf("FAIL %0t: row %0d opcode %0d, expected %0d", $time, r, got, exp));
    end
  endtask

  task automatic check_error(input logic got, input logic exp, input int r);
    if (got !== exp) begin
      stop_on_error($sformatf("FAIL %0t: row %0d error %b, expected %b", $time, r, got, exp));
    end
  endtask

  // Galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // Host index sits in the low bit, so the source comes back shifted right
  function automatic tl_source_t rsp_source(input tl_source_t src);
    return src >> 1;
  endfunction

  // Table entry, expected values from the reference memory in table order
  task automatic add_row(input int host, input bit both, input bit stall, input tl_a_op_e op,
                         input tl_addr_t addr, input tl_mask_t mask, input tl_data_t data,
                         input tl_source_t src);
    row_t rw;
    int   idx;
    rw = '{host: host, both: both, stall: stall, op: op, addr: addr, mask: mask, data: data,
           src: src, exp_op: AccessAck, exp_data: '0, exp_err: 1'b0};
    rw.exp_op = (op == Get) ? AccessAckData : AccessAck;
    idx = int'(addr[5:2]);
    if (addr >= MemBytes) begin
      rw.exp_err = 1'b1;
    end else if (op == Get) begin
      rw.exp_data = ref_mem[idx];
    end else begin
      for (int b = 0; b < MaskW; b++) begin
        if (mask[b]) ref_mem[idx][8*b +: 8] = data[8*b +: 8];
      end
    end
    rows.push_back(rw);
  endtask

  function automatic int pending(input int h);
    return (h == 0) ? got_q0.size() : got_q1.size();
  endfunction

  // Hold the beat until the host FIFO takes it
  task automatic issue_row(input int r);
    int h;
    bit taken;
    h = rows[r].host;
    @(negedge clk_i);
    a_valid[h]   = 1'b1;
    a_opcode[h]  = rows[r].op;
    a_address[h] = rows[r].addr;
    a_mask[h]    = rows[r].mask;
    a_data[h]    = rows[r].data;
    a_source[h]  = rows[r].src;
    do begin
      #1 taken = a_ready[h];
      @(negedge clk_i);
    end while (!taken);
    a_valid[h] = 1'b0;
  endtask

  task automatic wait_rsp(input int r);
    int   h;
    rsp_t got;
    h = rows[r].host;
    while (pending(h) == 0) @(negedge clk_i);
    got = (h == 0) ? got_q0.pop_front() : got_q1.pop_front();
    check_opcode(got.op, rows[r].exp_op, r);
    check_data(got.data, rows[r].exp_data, r);
    check_source(got.src, rsp_source(rows[r].src), r);
    check_error(got.err, rows[r].exp_err, r);
  endtask

  // D channel ready and response capture, one LFSR bit per host per cycle
  initial begin
    logic [31:0] lfsr;
    rsp_t        rsp;
    lfsr    = 32'h83a1_90f0;
    d_ready = '{default: 1'b1};
    forever begin
      @(negedge clk_i);
      for (int h = 0; h < M; h++) begin
        if (stall_on) begin
          d_ready[h] = lfsr[0];
          lfsr       = lfsr_step(lfsr);
        end else begin
          d_ready[h] = 1'b1;
        end
      end
      #1;
      for (int h = 0; h < M; h++) begin
        if (d_valid[h] && d_ready[h]) begin
          rsp.op   = d_opcode[h];
          rsp.data = d_data[h];
          rsp.src  = d_source[h];
          rsp.err  = d_error[h];
          if (h == 0) got_q0.push_back(rsp);
          else got_q1.push_back(rsp);
        end
      end
    end
  end

  initial begin
    int r;
    reset_i   = 1'b1;
    a_valid   = '{default: 1'b0};
    a_opcode  = '{default: Get};
    a_address = '{default: '0};
    a_mask    = '{default: '0};
    a_data    = '{default: '0};
    a_source  = '{default: '0};
    ref_mem   = '{default: '0};
    // Write then read, partial mask, range errors, paired hosts, stalls
    add_row(0, 0, 0, PutFullData, 32'h00, 4'hf, 32'h1122_3344, 4'h5);
    add_row(0, 0, 0, Get,         32'h00, 4'hf, 32'h0,         4'h5);
    add_row(1, 0, 0, PutFullData, 32'h00, 4'h5, 32'haabb_ccdd, 4'h9);
    add_row(1, 0, 0, Get,         32'h00, 4'hf, 32'h0,         4'ha);
    add_row(0, 0, 0, PutFullData, 32'h40, 4'hf, 32'hdead_beef, 4'h3);
    add_row(0, 0, 0, Get,         32'h40, 4'hf, 32'h0,         4'h3);
    add_row(1, 0, 0, Get,         32'h00, 4'hf, 32'h0,         4'hf);
    add_row(0, 1, 0, PutFullData, 32'h08, 4'hf, 32'h0102_0304, 4'h2);
    add_row(1, 1, 0, PutFullData, 32'h0c, 4'hf, 32'h0a0b_0c0d, 4'h7);
    add_row(0, 1, 0, Get,         32'h08, 4'hf, 32'h0,         4'hc);
    add_row(1, 1, 0, Get,         32'h0c, 4'hf, 32'h0,         4'h6);
    add_row(0, 0, 1, PutFullData, 32'h10, 4'h3, 32'h5566_7788, 4'h1);
    add_row(1, 0, 1, Get,         32'h10, 4'hf, 32'h0,         4'h4);
    add_row(0, 1, 1, Get,         32'h08, 4'hf, 32'h0,         4'h8);
    add_row(1, 1, 1, Get,         32'h3c, 4'hf, 32'h0,         4'hb);
    add_row(0, 0, 1, Get,         32'h7c, 4'hf, 32'h0,         4'hd);
    fork
      begin
        repeat (rows.size() * 200) @(posedge clk_i);
        stop_on_error("timeout waiting for response");
      end
    join_none
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    r = 0;
    while (r < rows.size()) begin
      // Change the stall mode away from the edge where ready is driven
      @(posedge clk_i);
      stall_on = rows[r].stall;
      if (rows[r].both) begin
        fork
          issue_row(r);
          issue_row(r + 1);
        join
        wait_rsp(r);
        wait_rsp(r + 1);
        r += 2;
      end else begin
        issue_row(r);
        wait_rsp(r);
        if (pending(1 - rows[r].host) != 0) stop_on_error("response on the wrong host port");
        r += 1;
      end
    end
    stall_on = 1'b0;
    repeat (10) @(negedge clk_i);
    if (pending(0) != 0 || pending(1) != 0) begin
      stop_on_error("extra response after the last request");
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: sim.f
rtl/tlul_pkg.sv
rtl/tlul_link_if.sv
rtl/tlul_fifo.sv
rtl/tlul_fifo_pair.sv
rtl/tlul_rr_arbiter.sv
rtl/tlul_socket_m1.sv
rtl/tlul_sram_dev.sv
rtl/tlul_xbar_top.sv
verification/tlul_xbar_assertions.sv
verification/tlul_xbar_tb.sv

// File: Makefile
TOP = tlul_xbar_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sim.f $(wildcard rtl/*.sv) $(wildcard verification/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall -f sim.f --top-module tlul_xbar_top

clean:
	rm -rf obj_dir sim.log
